// ==== src/vdma_config.svh ====
`ifndef VDMA_CONFIG_SVH
`define VDMA_CONFIG_SVH

// --------------------
// Image geometry
// --------------------

// Pixels per line
`define IMG_WIDTH 16
// Lines per frame
`define IMG_HEIGHT 4
// Bits per pixel
`define PIXEL_WIDTH 8

// --------------------
// Bus and buffering
// --------------------

`define ADDR_WIDTH 32
`define DATA_WIDTH 32
// Beats per AXI burst
`define BURST_LEN 4
// Must hold at least one whole burst
`define FIFO_DEPTH 8

`endif

// ==== src/axi_rd_pkg.sv ====
`include "vdma_config.svh"

package axi_rd_pkg;

	// Address and data beat
	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DATA_WIDTH-1:0] data_t;

	// Read response, bit 1 set on SLVERR or DECERR
	typedef logic [1:0] resp_t;

	// --------------------
	// Burst encodings
	// --------------------

	// Byte stride between consecutive bursts
	localparam int BURST_BYTES = `BURST_LEN * `DATA_WIDTH / 8;

	// Beats minus one
	localparam logic [7:0] ARLEN_VAL = 8'(`BURST_LEN - 1);
	// log2 of bytes per beat
	localparam logic [2:0] ARSIZE_VAL = 3'($clog2(`DATA_WIDTH / 8));
	localparam logic [1:0] BURST_INCR = 2'b01;

endpackage

// ==== src/video_pkg.sv ====
`include "vdma_config.svh"

package video_pkg;

	localparam int PIX_PER_WORD = `DATA_WIDTH / `PIXEL_WIDTH;

	typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

	// One bus word, seen as a raw beat or as its pixel lanes
	// Lane 0 sits in the lowest byte and is shown first
	typedef union packed {
		axi_rd_pkg::data_t raw;
		pixel_t [PIX_PER_WORD-1:0] pix;
	} pix_word_u;

	// --------------------
	// Frame position
	// --------------------

	localparam int WORDS_PER_LINE = `IMG_WIDTH / PIX_PER_WORD;
	localparam int BURSTS_PER_FRAME = WORDS_PER_LINE * `IMG_HEIGHT / `BURST_LEN;

	// Word index within a line
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] col_t;
	// Line index within a frame
	typedef logic [$clog2(`IMG_HEIGHT)-1:0] row_t;
	// Pixel lane within a word
	typedef logic [$clog2(PIX_PER_WORD)-1:0] lane_t;

endpackage

// ==== src/word_fifo_if.sv ====
`timescale 1ns/1ps

interface word_fifo_if (
	input logic M_AXI_ACLK
);
	import video_pkg::*;

	// Write side, word and its tags
	pix_word_u word;
	logic sof;
	logic eol;
	logic push;

	// Levels from the buffer
	logic full;
	logic burst_room;
	logic empty;

	// Head of the buffer
	pix_word_u q_word;
	logic q_sof;
	logic q_eol;
	logic pop;

	modport producer (output word, sof, eol, push, input full, burst_room);

	modport store (
		input word, sof, eol, push, pop,
		output full, burst_room, empty, q_word, q_sof, q_eol
	);

	modport consumer (input q_word, q_sof, q_eol, empty, output pop);

endinterface

// ==== src/frame_fetch.sv ====
`timescale 1ns/1ps
`include "vdma_config.svh"

module frame_fetch (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input axi_rd_pkg::addr_t base_addr,

	output axi_rd_pkg::addr_t M_AXI_ARADDR,
	output logic [7:0] M_AXI_ARLEN,
	output logic [2:0] M_AXI_ARSIZE,
	output logic [1:0] M_AXI_ARBURST,
	output logic M_AXI_ARVALID,
	input logic M_AXI_ARREADY,

	input axi_rd_pkg::data_t M_AXI_RDATA,
	input axi_rd_pkg::resp_t M_AXI_RRESP,
	input logic M_AXI_RLAST,
	input logic M_AXI_RVALID,
	output logic M_AXI_RREADY,

	output logic frame_pulse,
	output logic resp_err,
	word_fifo_if.producer fifo
);
	import axi_rd_pkg::*;
	import video_pkg::*;

	localparam int BCNT_W = $clog2(BURSTS_PER_FRAME);

	logic burst_active;
	logic start_burst;
	logic rnext;
	logic [BCNT_W-1:0] burst_cnt;
	col_t col;
	row_t row;

	assign M_AXI_ARLEN = ARLEN_VAL;
	assign M_AXI_ARSIZE = ARSIZE_VAL;
	assign M_AXI_ARBURST = BURST_INCR;

	// --------------------
	// Address channel
	// --------------------

	// One burst in flight, and only once the FIFO can take all of it
	assign start_burst = !burst_active && fifo.burst_room;
	assign frame_pulse = start_burst && (burst_cnt == '0);

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			M_AXI_ARVALID <= 1'b0;
			burst_active <= 1'b0;
		end else begin
			if (start_burst) begin
				M_AXI_ARVALID <= 1'b1;
				burst_active <= 1'b1;
			end else if (M_AXI_ARVALID && M_AXI_ARREADY) begin
				M_AXI_ARVALID <= 1'b0;
			end
			if (rnext && M_AXI_RLAST)
				burst_active <= 1'b0;
		end
	end

	// Loaded with ARVALID, so it holds still until the handshake
	always_ff @(posedge M_AXI_ACLK) begin
		if (start_burst) begin
			if (burst_cnt == '0)
				M_AXI_ARADDR <= base_addr;
			else
				M_AXI_ARADDR <= M_AXI_ARADDR + addr_t'(BURST_BYTES);
		end
	end

	// Bursts done in this frame, wraps on the frame's last beat
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			burst_cnt <= '0;
		else if (rnext && M_AXI_RLAST)
			burst_cnt <= (burst_cnt == BCNT_W'(BURSTS_PER_FRAME - 1)) ? '0 : burst_cnt + 1'b1;
	end

	// --------------------
	// Data channel
	// --------------------

	assign M_AXI_RREADY = !fifo.full;
	assign rnext = M_AXI_RVALID && M_AXI_RREADY;
	assign resp_err = rnext && M_AXI_RRESP[1];

	// Every accepted beat goes straight into the FIFO
	assign fifo.push = rnext;
	assign fifo.word.raw = M_AXI_RDATA;
	assign fifo.sof = (col == '0) && (row == '0);
	assign fifo.eol = (col == col_t'(WORDS_PER_LINE - 1));

	// Position of the next beat in the frame
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			col <= '0;
			row <= '0;
		end else if (rnext) begin
			if (col == col_t'(WORDS_PER_LINE - 1)) begin
				col <= '0;
				if (row == row_t'(`IMG_HEIGHT - 1))
					row <= '0;
				else
					row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

endmodule

// ==== src/line_fifo.sv ====
`timescale 1ns/1ps
`include "vdma_config.svh"

module line_fifo (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	word_fifo_if.store fifo
);
	import video_pkg::*;

	localparam int DEPTH = `FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	pix_word_u mem_word [DEPTH];
	logic mem_sof [DEPTH];
	logic mem_eol [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = fifo.push && !fifo.full;
	assign do_pop = fifo.pop && !fifo.empty;

	// Storage, no reset on the words
	always_ff @(posedge M_AXI_ACLK) begin
		if (do_push) begin
			mem_word[wr_ptr] <= fifo.word;
			mem_sof[wr_ptr] <= fifo.sof;
			mem_eol[wr_ptr] <= fifo.eol;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Head of queue, read straight from the array
	assign fifo.q_word = mem_word[rd_ptr];
	assign fifo.q_sof = mem_sof[rd_ptr];
	assign fifo.q_eol = mem_eol[rd_ptr];

	// Levels
	assign fifo.empty = (count == '0);
	assign fifo.full = (count == CNT_W'(DEPTH));
	assign fifo.burst_room = (CNT_W'(DEPTH) - count) >= CNT_W'(`BURST_LEN);

endmodule

// ==== src/pixel_unpack.sv ====
`timescale 1ns/1ps

module pixel_unpack (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	word_fifo_if.consumer fifo,
	input logic pix_hold,
	output video_pkg::pixel_t pix_data,
	output logic pix_valid,
	output logic pix_sof,
	output logic pix_eol
);
	import video_pkg::*;

	localparam lane_t LAST_LANE = lane_t'(PIX_PER_WORD - 1);

	pix_word_u cur;
	logic cur_sof;
	logic cur_eol;
	logic loaded;
	lane_t lane;
	logic last_out;

	// --------------------
	// Word fetch
	// --------------------

	assign pix_valid = loaded && !pix_hold;
	assign last_out = pix_valid && (lane == LAST_LANE);

	// Refill when idle or as the last lane leaves
	assign fifo.pop = !fifo.empty && (!loaded || last_out);

	always_ff @(posedge M_AXI_ACLK) begin
		if (fifo.pop) begin
			cur <= fifo.q_word;
			cur_sof <= fifo.q_sof;
			cur_eol <= fifo.q_eol;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			loaded <= 1'b0;
			lane <= '0;
		end else if (fifo.pop) begin
			loaded <= 1'b1;
			lane <= '0;
		end else if (last_out) begin
			// Drained and nothing waiting
			loaded <= 1'b0;
		end else if (pix_valid) begin
			lane <= lane + 1'b1;
		end
	end

	// --------------------
	// Pixel output
	// --------------------

	assign pix_data = cur.pix[lane];
	assign pix_sof = pix_valid && cur_sof && (lane == '0);
	assign pix_eol = last_out && cur_eol;

endmodule

// ==== src/vdma_rd_top.sv ====
`timescale 1ns/1ps

module vdma_rd_top (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,

	// AXI read address
	output axi_rd_pkg::addr_t M_AXI_ARADDR,
	output logic [7:0] M_AXI_ARLEN,
	output logic [2:0] M_AXI_ARSIZE,
	output logic [1:0] M_AXI_ARBURST,
	output logic M_AXI_ARVALID,
	input logic M_AXI_ARREADY,

	// AXI read data
	input axi_rd_pkg::data_t M_AXI_RDATA,
	input axi_rd_pkg::resp_t M_AXI_RRESP,
	input logic M_AXI_RLAST,
	input logic M_AXI_RVALID,
	output logic M_AXI_RREADY,

	// Control and status
	input axi_rd_pkg::addr_t base_addr,
	output logic frame_pulse,
	output logic resp_err,

	// Pixel stream
	output video_pkg::pixel_t pix_data,
	output logic pix_valid,
	output logic pix_sof,
	output logic pix_eol,
	input logic pix_hold
);

	word_fifo_if fifo_if (.M_AXI_ACLK(M_AXI_ACLK));

	frame_fetch frame_fetch_inst (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.base_addr(base_addr),
		.M_AXI_ARADDR(M_AXI_ARADDR),
		.M_AXI_ARLEN(M_AXI_ARLEN),
		.M_AXI_ARSIZE(M_AXI_ARSIZE),
		.M_AXI_ARBURST(M_AXI_ARBURST),
		.M_AXI_ARVALID(M_AXI_ARVALID),
		.M_AXI_ARREADY(M_AXI_ARREADY),
		.M_AXI_RDATA(M_AXI_RDATA),
		.M_AXI_RRESP(M_AXI_RRESP),
		.M_AXI_RLAST(M_AXI_RLAST),
		.M_AXI_RVALID(M_AXI_RVALID),
		.M_AXI_RREADY(M_AXI_RREADY),
		.frame_pulse(frame_pulse),
		.resp_err(resp_err),
		.fifo(fifo_if.producer)
	);

	line_fifo line_fifo_inst (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.fifo(fifo_if.store)
	);

	pixel_unpack pixel_unpack_inst (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.fifo(fifo_if.consumer),
		.pix_hold(pix_hold),
		.pix_data(pix_data),
		.pix_valid(pix_valid),
		.pix_sof(pix_sof),
		.pix_eol(pix_eol)
	);

endmodule

// ==== dv/vdma_rd_chk.sv ====
`timescale 1ns/1ps
`include "vdma_config.svh"

module vdma_rd_chk (
	input logic M_AXI_ACLK,
	input logic M_AXI_ARESETN,
	input axi_rd_pkg::addr_t base_addr,
	input axi_rd_pkg::addr_t M_AXI_ARADDR,
	input logic [7:0] M_AXI_ARLEN,
	input logic [2:0] M_AXI_ARSIZE,
	input logic [1:0] M_AXI_ARBURST,
	input logic M_AXI_ARVALID,
	input logic M_AXI_ARREADY,
	input axi_rd_pkg::resp_t M_AXI_RRESP,
	input logic M_AXI_RVALID,
	input logic M_AXI_RREADY,
	input logic frame_pulse,
	input logic resp_err,
	input video_pkg::pixel_t pix_data,
	input logic pix_valid,
	input logic pix_sof,
	input logic pix_eol
);
	import axi_rd_pkg::*;
	import video_pkg::*;

	localparam int FRAME_PIX = `IMG_WIDTH * `IMG_HEIGHT;

	int err_cnt = 0;
	int pix_idx;
	int burst_idx;
	logic started;
	pixel_t exp_pix;

	// --------------------
	// Frame position
	// --------------------

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			pix_idx <= 0;
			burst_idx <= 0;
			started <= 1'b0;
		end else begin
			if (pix_valid)
				pix_idx <= (pix_idx == FRAME_PIX - 1) ? 0 : pix_idx + 1;
			if (M_AXI_ARVALID && M_AXI_ARREADY)
				burst_idx <= (burst_idx == BURSTS_PER_FRAME - 1) ? 0 : burst_idx + 1;
			if (frame_pulse)
				started <= 1'b1;
		end
	end

	// Each byte in memory holds the low bits of its own address
	assign exp_pix = pixel_t'(base_addr[7:0] + 8'(pix_idx));

	// --------------------
	// Assertions
	// --------------------

	a_reset_quiet: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		!started && !frame_pulse |-> !M_AXI_ARVALID && !pix_valid && !resp_err)
	else begin
		$error("Outputs were active before the first burst started at %0t", $time);
		err_cnt++;
	end

	a_pixel: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		pix_valid |-> pix_data == exp_pix)
	else begin
		$error("[ERROR] %0t pix_data got %02h expected %02h", $time,
			$sampled(pix_data), $sampled(exp_pix));
		err_cnt++;
	end

	a_sof: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		pix_valid |-> pix_sof == (pix_idx == 0))
	else begin
		$error("[ERROR] %0t pix_sof got %0b expected %0b", $time,
			$sampled(pix_sof), $sampled(pix_idx == 0));
		err_cnt++;
	end

	a_eol: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		pix_valid |-> pix_eol == (pix_idx % `IMG_WIDTH == `IMG_WIDTH - 1))
	else begin
		$error("[ERROR] %0t pix_eol got %0b expected %0b", $time, $sampled(pix_eol),
			$sampled(pix_idx % `IMG_WIDTH == `IMG_WIDTH - 1));
		err_cnt++;
	end

	a_araddr: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_ARVALID |-> M_AXI_ARADDR == base_addr + addr_t'(burst_idx * BURST_BYTES))
	else begin
		$error("[ERROR] %0t M_AXI_ARADDR got %08h expected %08h", $time,
			$sampled(M_AXI_ARADDR), $sampled(base_addr + addr_t'(burst_idx * BURST_BYTES)));
		err_cnt++;
	end

	// Four beats of four bytes, incrementing
	a_arfields: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_ARVALID |-> M_AXI_ARLEN == 8'(`BURST_LEN - 1) && M_AXI_ARSIZE == 3'd2
			&& M_AXI_ARBURST == 2'b01)
	else begin
		$error("[ERROR] %0t ARLEN/ARSIZE/ARBURST got %0d/%0d/%0d expected %0d/2/1", $time,
			$sampled(M_AXI_ARLEN), $sampled(M_AXI_ARSIZE), $sampled(M_AXI_ARBURST),
			`BURST_LEN - 1);
		err_cnt++;
	end

	a_arvalid_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_ARVALID && !M_AXI_ARREADY |=> M_AXI_ARVALID && $stable(M_AXI_ARADDR))
	else begin
		$error("ARVALID dropped or ARADDR moved before ARREADY at %0t", $time);
		err_cnt++;
	end

	// One pulse per frame, just ahead of the frame's first address
	a_frame_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		frame_pulse |=> M_AXI_ARVALID && burst_idx == 0)
	else begin
		$error("frame_pulse was not followed by the first burst of a frame at %0t", $time);
		err_cnt++;
	end

	a_frame_start: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		$rose(M_AXI_ARVALID) && burst_idx == 0 |-> $past(frame_pulse))
	else begin
		$error("First burst of a frame started without frame_pulse at %0t", $time);
		err_cnt++;
	end

	a_resp_err: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		resp_err == (M_AXI_RVALID && M_AXI_RREADY && M_AXI_RRESP[1]))
	else begin
		$error("[ERROR] %0t resp_err got %0b expected %0b", $time, $sampled(resp_err),
			$sampled(M_AXI_RVALID && M_AXI_RREADY && M_AXI_RRESP[1]));
		err_cnt++;
	end

endmodule

bind vdma_rd_top vdma_rd_chk chk_inst (.*);

// ==== dv/vdma_rd_tb.sv ====
`timescale 1ns/1ps
`include "vdma_config.svh"

module vdma_rd_tb;
	import axi_rd_pkg::*;
	import video_pkg::*;

	localparam int FRAME_PIX = `IMG_WIDTH * `IMG_HEIGHT;
	localparam int FRAME_BEATS = FRAME_PIX / PIX_PER_WORD;
	// Eight frames over all tests, ten cycles per beat at worst, twice over
	localparam int CYCLE_LIMIT = 2 * 8 * FRAME_BEATS * 10 + 200;
	// Burst that answers with SLVERR when injection is on
	localparam int ERR_BURST = 5;

	logic M_AXI_ACLK = 1'b0;
	logic M_AXI_ARESETN = 1'b0;
	addr_t M_AXI_ARADDR;
	logic [7:0] M_AXI_ARLEN;
	logic [2:0] M_AXI_ARSIZE;
	logic [1:0] M_AXI_ARBURST;
	logic M_AXI_ARVALID;
	logic M_AXI_ARREADY = 1'b0;
	data_t M_AXI_RDATA = '0;
	resp_t M_AXI_RRESP = '0;
	logic M_AXI_RLAST = 1'b0;
	logic M_AXI_RVALID = 1'b0;
	logic M_AXI_RREADY;
	addr_t base_addr = 32'h0000_1040;
	logic frame_pulse;
	logic resp_err;
	pixel_t pix_data;
	logic pix_valid;
	logic pix_sof;
	logic pix_eol;
	logic pix_hold = 1'b0;

	int seed = 32'haa6ebeab;
	logic waits = 1'b0;
	logic hold_rand = 1'b0;
	logic err_inject = 1'b0;

	// Slave model state
	logic busy = 1'b0;
	logic r_fire = 1'b0;
	addr_t rd_addr = '0;
	int beat = 0;
	int burst_no = 0;

	int cycles = 0;
	int pix_cnt = 0;
	int resp_cnt = 0;
	int tests = 0;
	int failed = 0;
	int err_start = 0;

	vdma_rd_top vdma_rd_top_inst (.*);

	initial begin
		forever #2 M_AXI_ACLK = ~M_AXI_ACLK;
	end

	function automatic data_t beat_word(input addr_t a);
		data_t w;
		for (int i = 0; i < `DATA_WIDTH / 8; i++)
			w[8*i +: 8] = 8'(a + addr_t'(i));
		return w;
	endfunction

	// --------------------
	// AXI slave memory
	// --------------------

	always @(negedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			busy = 1'b0;
			r_fire = 1'b0;
			beat = 0;
			burst_no = 0;
			M_AXI_ARREADY = 1'b0;
			M_AXI_RVALID = 1'b0;
			M_AXI_RLAST = 1'b0;
		end else begin
			// Beat taken at the last rising edge
			if (r_fire) begin
				beat = beat + 1;
				if (beat == `BURST_LEN) begin
					busy = 1'b0;
					burst_no = burst_no + 1;
				end
			end
			if (!busy) begin
				M_AXI_RVALID = 1'b0;
				M_AXI_RLAST = 1'b0;
				M_AXI_ARREADY = !waits || (($random(seed) & 1) != 0);
				if (M_AXI_ARREADY && M_AXI_ARVALID) begin
					busy = 1'b1;
					rd_addr = M_AXI_ARADDR;
					beat = 0;
				end
			end else begin
				M_AXI_ARREADY = 1'b0;
				if (r_fire || !M_AXI_RVALID)
					M_AXI_RVALID = !waits || (($random(seed) & 1) != 0);
				M_AXI_RDATA = beat_word(rd_addr + addr_t'(beat * (`DATA_WIDTH / 8)));
				M_AXI_RLAST = (beat == `BURST_LEN - 1);
				M_AXI_RRESP = (err_inject && burst_no == ERR_BURST) ? 2'b10 : 2'b00;
			end
			r_fire = M_AXI_RVALID && M_AXI_RREADY;
			pix_hold = hold_rand && (($random(seed) & 1) != 0);
		end
	end

	// Pixel and error pulse counts, plus the run limit
	always @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			pix_cnt <= 0;
			resp_cnt <= 0;
		end else begin
			pix_cnt <= pix_cnt + (pix_valid ? 1 : 0);
			resp_cnt <= resp_cnt + (resp_err ? 1 : 0);
		end
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end else begin
			cycles <= cycles + 1;
		end
	end

	// --------------------
	// Tests
	// --------------------

	task automatic reset_dut();
		@(negedge M_AXI_ACLK);
		M_AXI_ARESETN = 1'b0;
		repeat (4) @(negedge M_AXI_ACLK);
		M_AXI_ARESETN = 1'b1;
	endtask

	task automatic wait_pixels(input int n);
		while (pix_cnt < n)
			@(negedge M_AXI_ACLK);
	endtask

	task automatic end_test(input string name, input int extra);
		int errs;
		errs = vdma_rd_top_inst.chk_inst.err_cnt - err_start + extra;
		err_start = vdma_rd_top_inst.chk_inst.err_cnt;
		tests++;
		if (errs != 0)
			failed++;
		$display("Test %0d %s: %s, %0d errors", tests, name, (errs == 0) ? "ok" : "FAILED", errs);
	endtask

	initial begin
		reset_dut();
		while (!M_AXI_ARVALID)
			@(negedge M_AXI_ACLK);
		wait_pixels(8);
		end_test("idle after reset", 0);

		reset_dut();
		wait_pixels(2 * FRAME_PIX);
		end_test("two frames without waits", 0);

		hold_rand = 1'b1;
		reset_dut();
		wait_pixels(2 * FRAME_PIX);
		end_test("random pix_hold", 0);

		hold_rand = 1'b0;
		waits = 1'b1;
		reset_dut();
		wait_pixels(2 * FRAME_PIX);
		end_test("random AXI waits", 0);

		err_inject = 1'b1;
		reset_dut();
		wait_pixels(2 * FRAME_PIX);
		if (resp_cnt != `BURST_LEN)
			$display("[ERROR] %0t resp_err pulses got %0d expected %0d", $time, resp_cnt,
				`BURST_LEN);
		end_test("SLVERR injection", (resp_cnt != `BURST_LEN) ? 1 : 0);

		$display("Tests run %0d, failed %0d", tests, failed);
		if (failed == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+src
src/axi_rd_pkg.sv
src/video_pkg.sv
src/word_fifo_if.sv
src/frame_fetch.sv
src/line_fifo.sv
src/pixel_unpack.sv
src/vdma_rd_top.sv
dv/vdma_rd_chk.sv
dv/vdma_rd_tb.sv

// ==== Makefile ====
TOP = vdma_rd_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module vdma_rd_top
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim +verilator+error+limit+1000 | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
